//--- rtl/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

  // write queue slots
  localparam int wq_width = 5;
  localparam int wq_slots = 32;

  // data cache banks, 4 bytes each
  localparam int bank_width = 3;
  localparam int bank_count = 8;
  localparam int low_width = 2;
  localparam int ben_width = 4;

  localparam int data_width = 64;
  // three banks of aligned store data
  localparam int line_width = 96;

  localparam int queue_depth = 8;
  localparam int queue_ptr_width = $clog2(queue_depth);
  localparam int queue_cnt_width = $clog2(queue_depth + 1);

  localparam int port_count = 2;

  // byte offset of the last stored byte, counted from the start bank
  localparam int last_width = low_width + 2;

  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_half  = 2'd1,
    size_word  = 2'd2,
    size_dword = 2'd3
  } store_size_e;

  // low + bytes - 1, so bits above low_width give the bank span
  function automatic logic [last_width-1:0] last_byte(
    input logic [low_width-1:0] low,
    input store_size_e size
  );
    return {2'b00, low} + (4'd1 << size) - 4'd1;
  endfunction

endpackage

`default_nettype wire

//--- rtl/store_data_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module store_data_buffer (
  input  logic clk,
  input  logic rst_n,
  input  logic [lsq_pkg::port_count-1:0] wdata_en,
  input  logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] wdata_wq,
  input  logic [lsq_pkg::port_count-1:0][lsq_pkg::data_width-1:0] wdata_data,
  input  logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] head_wq,
  input  logic [lsq_pkg::port_count-1:0] issue_en,
  output logic [lsq_pkg::port_count-1:0] slot_ready,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::data_width-1:0] read_data
);

  logic [lsq_pkg::data_width-1:0] mem [lsq_pkg::wq_slots];
  logic [lsq_pkg::wq_slots-1:0] ready;
  logic write_free_hit;

  // data slots
  always_ff @(posedge clk) begin
    for (int p = 0; p < lsq_pkg::port_count; p++) begin
      if (wdata_en[p]) begin
        mem[wdata_wq[p]] <= wdata_data[p];
      end
    end
  end

  // ready bits, set by a write and cleared when the slot issues
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready <= '0;
    end else begin
      for (int p = 0; p < lsq_pkg::port_count; p++) begin
        if (issue_en[p]) begin
          ready[head_wq[p]] <= 1'b0;
        end
      end
      for (int p = 0; p < lsq_pkg::port_count; p++) begin
        if (wdata_en[p]) begin
          ready[wdata_wq[p]] <= 1'b1;
        end
      end
    end
  end

  // heads read combinationally
  always_comb begin
    for (int p = 0; p < lsq_pkg::port_count; p++) begin
      slot_ready[p] = ready[head_wq[p]];
      read_data[p] = mem[head_wq[p]];
    end
  end

  always_comb begin
    write_free_hit = 1'b0;
    for (int p = 0; p < lsq_pkg::port_count; p++) begin
      for (int q = 0; q < lsq_pkg::port_count; q++) begin
        if (wdata_en[p] && issue_en[q] && wdata_wq[p] == head_wq[q]) begin
          write_free_hit = 1'b1;
        end
      end
    end
  end

  // a slot cannot be refilled while the queue frees it
  a_no_write_on_free: assert property (
    @(posedge clk) disable iff (!rst_n) !write_free_hit
  ) else $error("data write to a slot that issues in the same cycle");

  a_no_dual_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(&wdata_en && wdata_wq[0] == wdata_wq[1])
  ) else $error("both data ports write slot %0d", wdata_wq[0]);

endmodule

`default_nettype wire

//--- rtl/store_issue_queue.sv
`timescale 1ns/10ps
`default_nettype none

module store_issue_queue (
  input  logic clk,
  input  logic rst_n,
  input  logic st_stall,
  input  logic push_en,
  input  logic [lsq_pkg::wq_width-1:0] push_wq,
  input  logic [lsq_pkg::bank_width-1:0] push_bank,
  input  logic [lsq_pkg::low_width-1:0] push_low,
  input  lsq_pkg::store_size_e push_size,
  input  logic [lsq_pkg::port_count-1:0] slot_ready,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] head_wq,
  output logic queue_full,
  output logic [lsq_pkg::port_count-1:0] issue_en,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] issue_wq,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::bank_width-1:0] issue_bank,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::low_width-1:0] issue_low,
  output lsq_pkg::store_size_e [lsq_pkg::port_count-1:0] issue_size
);

  logic [lsq_pkg::wq_width-1:0] e_wq [lsq_pkg::queue_depth];
  logic [lsq_pkg::bank_width-1:0] e_bank [lsq_pkg::queue_depth];
  logic [lsq_pkg::low_width-1:0] e_low [lsq_pkg::queue_depth];
  lsq_pkg::store_size_e e_size [lsq_pkg::queue_depth];

  logic [lsq_pkg::queue_ptr_width-1:0] rd_ptr;
  logic [lsq_pkg::queue_ptr_width-1:0] rd_ptr_1;
  logic [lsq_pkg::queue_ptr_width-1:0] wr_ptr;
  logic [lsq_pkg::queue_cnt_width-1:0] count;
  logic stall_q;
  logic [1:0] pop_num;
  logic [lsq_pkg::bank_count-1:0] mask0;
  logic [lsq_pkg::bank_count-1:0] mask1;

  // banks from the start bank through the end bank with wrap at the top
  function automatic logic [lsq_pkg::bank_count-1:0] bank_mask(
    input logic [lsq_pkg::bank_width-1:0] bank,
    input logic [lsq_pkg::low_width-1:0] low,
    input lsq_pkg::store_size_e size
  );
    logic [lsq_pkg::last_width-1:0] last;
    logic [lsq_pkg::bank_width-1:0] idx;
    logic [lsq_pkg::bank_count-1:0] mask;
    last = lsq_pkg::last_byte(low, size);
    mask = '0;
    idx = bank;
    for (int i = 0; i < 3; i++) begin
      if (i <= int'(last[lsq_pkg::last_width-1:lsq_pkg::low_width])) begin
        mask[idx] = 1'b1;
      end
      idx = idx + 1'b1;
    end
    return mask;
  endfunction

  assign rd_ptr_1 = rd_ptr + 1'b1;

  always_comb begin
    issue_wq[0] = e_wq[rd_ptr];
    issue_bank[0] = e_bank[rd_ptr];
    issue_low[0] = e_low[rd_ptr];
    issue_size[0] = e_size[rd_ptr];
    issue_wq[1] = e_wq[rd_ptr_1];
    issue_bank[1] = e_bank[rd_ptr_1];
    issue_low[1] = e_low[rd_ptr_1];
    issue_size[1] = e_size[rd_ptr_1];
  end

  assign head_wq = issue_wq;

  assign mask0 = bank_mask(issue_bank[0], issue_low[0], issue_size[0]);
  assign mask1 = bank_mask(issue_bank[1], issue_low[1], issue_size[1]);

  // dual issue only behind head 0 and on disjoint banks
  assign issue_en[0] = (count != '0) && !stall_q && slot_ready[0];
  assign issue_en[1] = issue_en[0] && (count > 1) && slot_ready[1] &&
                       ((mask0 & mask1) == '0);

  // 2'b10 for two pops, 2'b01 for one
  assign pop_num = {issue_en[1], issue_en[0] ^ issue_en[1]};

  assign queue_full = (count == lsq_pkg::queue_depth);

  always_ff @(posedge clk) begin
    if (push_en) begin
      e_wq[wr_ptr] <= push_wq;
      e_bank[wr_ptr] <= push_bank;
      e_low[wr_ptr] <= push_low;
      e_size[wr_ptr] <= push_size;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
      stall_q <= 1'b0;
    end else begin
      stall_q <= st_stall;
      rd_ptr <= rd_ptr + {{(lsq_pkg::queue_ptr_width - 2){1'b0}}, pop_num};
      if (push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      count <= count + {{(lsq_pkg::queue_cnt_width - 1){1'b0}}, push_en}
                     - {{(lsq_pkg::queue_cnt_width - 2){1'b0}}, pop_num};
    end
  end

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) push_en |-> !queue_full
  ) else $error("store pushed into a full issue queue");

endmodule

`default_nettype wire

//--- rtl/store_port_lane.sv
`timescale 1ns/10ps
`default_nettype none

module store_port_lane (
  input  logic clk,
  input  logic rst_n,
  input  logic issue_en,
  input  logic [lsq_pkg::wq_width-1:0] issue_wq,
  input  logic [lsq_pkg::bank_width-1:0] issue_bank,
  input  logic [lsq_pkg::low_width-1:0] issue_low,
  input  lsq_pkg::store_size_e issue_size,
  input  logic [lsq_pkg::data_width-1:0] read_data,
  output logic st_en,
  output logic [lsq_pkg::wq_width-1:0] st_wq,
  output logic [lsq_pkg::bank_width-1:0] st_bank,
  output logic [lsq_pkg::bank_width-1:0] st_end_bank,
  output logic [lsq_pkg::ben_width-1:0] st_bgn_ben,
  output logic [lsq_pkg::ben_width-1:0] st_end_ben,
  output logic [lsq_pkg::line_width-1:0] st_data
);

  logic [lsq_pkg::last_width-1:0] last;
  logic [1:0] span;
  logic [lsq_pkg::bank_width-1:0] end_bank;
  logic [lsq_pkg::ben_width-1:0] bgn_ben;
  logic [lsq_pkg::ben_width-1:0] end_ben;
  logic [lsq_pkg::data_width-1:0] kept;
  logic [lsq_pkg::line_width-1:0] aligned;

  assign last = lsq_pkg::last_byte(issue_low, issue_size);
  // banks crossed past the start bank
  assign span = last[lsq_pkg::last_width-1:lsq_pkg::low_width];
  assign end_bank = issue_bank + {1'b0, span};

  always_comb begin
    for (int i = 0; i < lsq_pkg::ben_width; i++) begin
      bgn_ben[i] = (i >= int'(issue_low)) && (i <= int'(last));
      if (span == 2'd0) begin
        end_ben[i] = bgn_ben[i];
      end else begin
        end_ben[i] = i <= int'(last[lsq_pkg::low_width-1:0]);
      end
    end
  end

  // keep the stored bytes only, then move them up to the offset
  always_comb begin
    for (int b = 0; b < lsq_pkg::data_width / 8; b++) begin
      if (b < (1 << issue_size)) begin
        kept[8*b +: 8] = read_data[8*b +: 8];
      end else begin
        kept[8*b +: 8] = 8'h00;
      end
    end
    aligned = {{(lsq_pkg::line_width - lsq_pkg::data_width){1'b0}}, kept}
              << {issue_low, 3'b000};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      st_en <= 1'b0;
    end else begin
      st_en <= issue_en;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_en) begin
      st_wq <= issue_wq;
      st_bank <= issue_bank;
      st_end_bank <= end_bank;
      st_bgn_ben <= bgn_ben;
      st_end_ben <= end_ben;
      st_data <= aligned;
    end
  end

endmodule

`default_nettype wire

//--- rtl/store_commit.sv
`timescale 1ns/10ps
`default_nettype none

module store_commit (
  input  logic clk,
  input  logic rst_n,
  input  logic push_en,
  input  logic [lsq_pkg::wq_width-1:0] push_wq,
  input  logic [lsq_pkg::bank_width-1:0] push_bank,
  input  logic [lsq_pkg::low_width-1:0] push_low,
  input  lsq_pkg::store_size_e push_size,
  input  logic [lsq_pkg::port_count-1:0] wdata_en,
  input  logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] wdata_wq,
  input  logic [lsq_pkg::port_count-1:0][lsq_pkg::data_width-1:0] wdata_data,
  input  logic st_stall,
  output logic queue_full,
  output logic [lsq_pkg::port_count-1:0] st_en,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] st_wq,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::bank_width-1:0] st_bank,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::bank_width-1:0] st_end_bank,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::ben_width-1:0] st_bgn_ben,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::ben_width-1:0] st_end_ben,
  output logic [lsq_pkg::port_count-1:0][lsq_pkg::line_width-1:0] st_data
);

  logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] head_wq;
  logic [lsq_pkg::port_count-1:0] slot_ready;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::data_width-1:0] read_data;
  logic [lsq_pkg::port_count-1:0] issue_en;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] issue_wq;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::bank_width-1:0] issue_bank;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::low_width-1:0] issue_low;
  lsq_pkg::store_size_e [lsq_pkg::port_count-1:0] issue_size;

  store_issue_queue siq (
    .clk(clk),
    .rst_n(rst_n),
    .st_stall(st_stall),
    .push_en(push_en),
    .push_wq(push_wq),
    .push_bank(push_bank),
    .push_low(push_low),
    .push_size(push_size),
    .slot_ready(slot_ready),
    .head_wq(head_wq),
    .queue_full(queue_full),
    .issue_en(issue_en),
    .issue_wq(issue_wq),
    .issue_bank(issue_bank),
    .issue_low(issue_low),
    .issue_size(issue_size)
  );

  store_data_buffer sdb (
    .clk(clk),
    .rst_n(rst_n),
    .wdata_en(wdata_en),
    .wdata_wq(wdata_wq),
    .wdata_data(wdata_data),
    .head_wq(head_wq),
    .issue_en(issue_en),
    .slot_ready(slot_ready),
    .read_data(read_data)
  );

  // one lane per data cache store port
  for (genvar p = 0; p < lsq_pkg::port_count; p++) begin : g_lane
    store_port_lane lane (
      .clk(clk),
      .rst_n(rst_n),
      .issue_en(issue_en[p]),
      .issue_wq(issue_wq[p]),
      .issue_bank(issue_bank[p]),
      .issue_low(issue_low[p]),
      .issue_size(issue_size[p]),
      .read_data(read_data[p]),
      .st_en(st_en[p]),
      .st_wq(st_wq[p]),
      .st_bank(st_bank[p]),
      .st_end_bank(st_end_bank[p]),
      .st_bgn_ben(st_bgn_ben[p]),
      .st_end_ben(st_end_ben[p]),
      .st_data(st_data[p])
    );
  end

endmodule

`default_nettype wire

//--- tests/store_vectors.svh
`ifndef STORE_VECTORS_SVH
`define STORE_VECTORS_SVH

// each row holds push fields, stall level, random flag, idle cycles and
// the expected queue_full after the idle cycles
// then the data write enables with slot and data of write ports 0 and 1
typedef struct packed {
  logic push;
  logic [lsq_pkg::wq_width-1:0] wq;
  logic [lsq_pkg::bank_width-1:0] bank;
  logic [lsq_pkg::low_width-1:0] low;
  lsq_pkg::store_size_e size;
  logic stall;
  logic rnd;
  logic [3:0] idle;
  logic full;
  logic [1:0] wr_en;
  logic [lsq_pkg::wq_width-1:0] wr0_wq;
  logic [lsq_pkg::data_width-1:0] wr0_data;
  logic [lsq_pkg::wq_width-1:0] wr1_wq;
  logic [lsq_pkg::data_width-1:0] wr1_data;
} vec_row_t;

localparam int row_count = 24;

localparam vec_row_t vectors [row_count] = '{
  // sizes and offsets, bank crossing and the wrap past bank 7
  '{1'b1, 5'd0, 3'd0, 2'd0, lsq_pkg::size_byte, 1'b0, 1'b0, 4'd0, 1'b0,
    2'b01, 5'd0, 64'h0123_4567_89ab_cdef, 5'd0, 64'h0},
  '{1'b1, 5'd1, 3'd2, 2'd1, lsq_pkg::size_half, 1'b0, 1'b0, 4'd0, 1'b0,
    2'b01, 5'd1, 64'hfedc_ba98_7654_3210, 5'd0, 64'h0},
  '{1'b1, 5'd2, 3'd3, 2'd3, lsq_pkg::size_half, 1'b0, 1'b0, 4'd0, 1'b0,
    2'b01, 5'd2, 64'h1122_3344_5566_7788, 5'd0, 64'h0},
  '{1'b1, 5'd3, 3'd5, 2'd2, lsq_pkg::size_word, 1'b0, 1'b0, 4'd0, 1'b0,
    2'b01, 5'd3, 64'h99aa_bbcc_ddee_ff00, 5'd0, 64'h0},
  '{1'b1, 5'd4, 3'd7, 2'd1, lsq_pkg::size_dword, 1'b0, 1'b0, 4'd0, 1'b0,
    2'b01, 5'd4, 64'ha5a5_5a5a_c3c3_3c3c, 5'd0, 64'h0},
  '{1'b1, 5'd5, 3'd7, 2'd3, lsq_pkg::size_word, 1'b0, 1'b0, 4'd2, 1'b0,
    2'b01, 5'd5, 64'hdead_beef_cafe_f00d, 5'd0, 64'h0},
  // random offsets and data
  '{1'b1, 5'd6, 3'd4, 2'd0, lsq_pkg::size_dword, 1'b0, 1'b1, 4'd0, 1'b0,
    2'b01, 5'd6, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd7, 3'd0, 2'd0, lsq_pkg::size_half, 1'b0, 1'b1, 4'd0, 1'b0,
    2'b01, 5'd7, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd8, 3'd6, 2'd0, lsq_pkg::size_word, 1'b0, 1'b1, 4'd2, 1'b0,
    2'b01, 5'd8, 64'h0, 5'd0, 64'h0},
  // pushed before the data and released by late writes
  '{1'b1, 5'd9, 3'd2, 2'd2, lsq_pkg::size_word, 1'b0, 1'b0, 4'd4, 1'b0,
    2'b00, 5'd0, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd10, 3'd5, 2'd0, lsq_pkg::size_byte, 1'b0, 1'b0, 4'd3, 1'b0,
    2'b01, 5'd10, 64'h0000_0000_0000_00e7, 5'd0, 64'h0},
  '{1'b0, 5'd0, 3'd0, 2'd0, lsq_pkg::size_byte, 1'b0, 1'b0, 4'd4, 1'b0,
    2'b01, 5'd9, 64'h7766_5544_3322_1100, 5'd0, 64'h0},
  // these two share bank 0 and go out one per cycle
  '{1'b1, 5'd11, 3'd0, 2'd0, lsq_pkg::size_word, 1'b0, 1'b0, 4'd0, 1'b0,
    2'b00, 5'd0, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd12, 3'd0, 2'd1, lsq_pkg::size_half, 1'b0, 1'b0, 4'd3, 1'b0,
    2'b11, 5'd11, 64'h0bad_f00d_1234_5678, 5'd12, 64'h8765_4321_0fed_cba9},
  // stall held while eight stores fill the queue
  '{1'b0, 5'd0, 3'd0, 2'd0, lsq_pkg::size_byte, 1'b1, 1'b0, 4'd1, 1'b0,
    2'b00, 5'd0, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd13, 3'd1, 2'd0, lsq_pkg::size_byte, 1'b1, 1'b1, 4'd0, 1'b0,
    2'b01, 5'd13, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd14, 3'd2, 2'd0, lsq_pkg::size_word, 1'b1, 1'b1, 4'd0, 1'b0,
    2'b01, 5'd14, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd15, 3'd6, 2'd0, lsq_pkg::size_dword, 1'b1, 1'b1, 4'd0, 1'b0,
    2'b01, 5'd15, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd16, 3'd0, 2'd0, lsq_pkg::size_half, 1'b1, 1'b1, 4'd0, 1'b0,
    2'b01, 5'd16, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd17, 3'd3, 2'd0, lsq_pkg::size_word, 1'b1, 1'b1, 4'd0, 1'b0,
    2'b01, 5'd17, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd18, 3'd7, 2'd0, lsq_pkg::size_dword, 1'b1, 1'b1, 4'd0, 1'b0,
    2'b01, 5'd18, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd19, 3'd5, 2'd0, lsq_pkg::size_byte, 1'b1, 1'b1, 4'd0, 1'b0,
    2'b01, 5'd19, 64'h0, 5'd0, 64'h0},
  '{1'b1, 5'd20, 3'd4, 2'd0, lsq_pkg::size_half, 1'b1, 1'b1, 4'd0, 1'b1,
    2'b01, 5'd20, 64'h0, 5'd0, 64'h0},
  // release
  '{1'b0, 5'd0, 3'd0, 2'd0, lsq_pkg::size_byte, 1'b0, 1'b0, 4'd3, 1'b0,
    2'b00, 5'd0, 64'h0, 5'd0, 64'h0}
};

`endif

//--- tests/store_commit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module store_commit_tb;

  logic clk;
  logic rst_n;
  logic push_en;
  logic [lsq_pkg::wq_width-1:0] push_wq;
  logic [lsq_pkg::bank_width-1:0] push_bank;
  logic [lsq_pkg::low_width-1:0] push_low;
  lsq_pkg::store_size_e push_size;
  logic [lsq_pkg::port_count-1:0] wdata_en;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] wdata_wq;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::data_width-1:0] wdata_data;
  logic st_stall;
  logic queue_full;
  logic [lsq_pkg::port_count-1:0] st_en;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::wq_width-1:0] st_wq;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::bank_width-1:0] st_bank;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::bank_width-1:0] st_end_bank;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::ben_width-1:0] st_bgn_ben;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::ben_width-1:0] st_end_ben;
  logic [lsq_pkg::port_count-1:0][lsq_pkg::line_width-1:0] st_data;

  typedef struct packed {
    logic [lsq_pkg::wq_width-1:0] wq;
    logic [lsq_pkg::bank_width-1:0] bank;
    logic [lsq_pkg::low_width-1:0] low;
    lsq_pkg::store_size_e size;
  } pending_t;

  // stores in push order, next_out is the next one due on a port
  pending_t pending [$];
  int next_out = 0;
  logic [lsq_pkg::data_width-1:0] slot_data [lsq_pkg::wq_slots];
  logic [lsq_pkg::wq_slots-1:0] slot_written;
  logic [31:0] lfsr;
  logic checking = 1'b0;
  logic [1:0] stall_hist = 2'b00;

  `include "store_vectors.svh"

  store_commit uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [95:0] got, input logic [95:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // galois lfsr, one step per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0000_0000);
    end
    return v;
  endfunction

  function automatic logic [7:0] bank_span(input logic [2:0] first, input logic [2:0] last_bank);
    logic [7:0] m;
    logic [2:0] b;
    m = 8'h00;
    b = first;
    m[b] = 1'b1;
    while (b != last_bank) begin
      b = b + 3'd1;
      m[b] = 1'b1;
    end
    return m;
  endfunction

  // expected fields from size, bank, offset and the written data
  task automatic check_port(input int p);
    pending_t e;
    logic [63:0] d;
    logic [3:0] bgn;
    logic [3:0] fin;
    logic [95:0] line;
    int n;
    int last;
    int endb;
    if (next_out >= pending.size()) begin
      fail_run($sformatf("error: st_en on port %0d with no store pending", p));
    end
    e = pending[next_out];
    next_out++;
    if (!slot_written[e.wq]) begin
      fail_run($sformatf("error: slot %0d reached port %0d before its data write", e.wq, p));
    end
    d = slot_data[e.wq];
    n = 1 << int'(e.size);
    last = int'(e.low) + n - 1;
    endb = (int'(e.bank) + last / 4) % 8;
    bgn = 4'h0;
    fin = 4'h0;
    line = '0;
    for (int i = 0; i < 4; i++) begin
      bgn[i] = (i >= int'(e.low)) && (i <= last);
      fin[i] = i <= last % 4;
    end
    if (endb == int'(e.bank)) begin
      fin = bgn;
    end
    for (int i = 0; i < n; i++) begin
      line[8*(int'(e.low) + i) +: 8] = d[8*i +: 8];
    end
    check_value($sformatf("st_wq[%0d]", p), 96'(st_wq[p]), 96'(e.wq));
    check_value($sformatf("st_bank[%0d]", p), 96'(st_bank[p]), 96'(e.bank));
    check_value($sformatf("st_end_bank[%0d]", p), 96'(st_end_bank[p]), 96'(endb));
    check_value($sformatf("st_bgn_ben[%0d]", p), 96'(st_bgn_ben[p]), 96'(bgn));
    check_value($sformatf("st_end_ben[%0d]", p), 96'(st_end_ben[p]), 96'(fin));
    check_value($sformatf("st_data[%0d]", p), st_data[p], line);
  endtask

  task automatic apply_row(input vec_row_t r);
    logic [63:0] bits;
    logic [1:0] low;
    logic [63:0] d0;
    logic [63:0] d1;
    low = r.low;
    d0 = r.wr0_data;
    d1 = r.wr1_data;
    if (r.rnd) begin
      bits = take_bits(2);
      low = bits[1:0];
      d0 = take_bits(64);
      d1 = take_bits(64);
    end
    push_en = r.push;
    push_wq = r.wq;
    push_bank = r.bank;
    push_low = low;
    push_size = r.size;
    wdata_en = r.wr_en;
    wdata_wq[0] = r.wr0_wq;
    wdata_wq[1] = r.wr1_wq;
    wdata_data[0] = d0;
    wdata_data[1] = d1;
    st_stall = r.stall;
    if (r.push) begin
      pending.push_back('{r.wq, r.bank, low, r.size});
    end
    if (r.wr_en[0]) begin
      slot_data[r.wr0_wq] = d0;
      slot_written[r.wr0_wq] = 1'b1;
    end
    if (r.wr_en[1]) begin
      slot_data[r.wr1_wq] = d1;
      slot_written[r.wr1_wq] = 1'b1;
    end
    @(negedge clk);
    push_en = 1'b0;
    wdata_en = 2'b00;
    repeat (r.idle) @(negedge clk);
    check_value("queue_full", 96'(queue_full), 96'(r.full));
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (next_out != pending.size() && t < 400) begin
      @(negedge clk);
      t++;
    end
    if (next_out != pending.size()) begin
      fail_run("error: timeout, pending stores never reached a store port");
    end
  endtask

  // stall seen two edges ago blocks st_en now
  always @(posedge clk) begin
    stall_hist <= {stall_hist[0], st_stall};
  end

  always @(negedge clk) begin
    if (checking) begin
      if (st_en[1] && !st_en[0]) begin
        fail_run("error: st_en on port 1 without port 0");
      end
      if (stall_hist[1] && st_en != 2'b00) begin
        fail_run("error: st_en while st_stall was held");
      end
      if (&st_en) begin
        check_value("bank overlap", 96'(bank_span(st_bank[0], st_end_bank[0]) &
                    bank_span(st_bank[1], st_end_bank[1])), 96'(0));
      end
      for (int p = 0; p < lsq_pkg::port_count; p++) begin
        if (st_en[p]) begin
          check_port(p);
        end
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    push_en = 1'b0;
    push_wq = '0;
    push_bank = '0;
    push_low = '0;
    push_size = lsq_pkg::size_byte;
    wdata_en = '0;
    wdata_wq = '0;
    wdata_data = '0;
    st_stall = 1'b0;
    slot_written = '0;
    lfsr = 32'h0fbc_3ec5;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    checking <= 1'b1;
    check_value("st_en", 96'(st_en), 96'(0));
    check_value("queue_full", 96'(queue_full), 96'(0));
    repeat (4) @(negedge clk);
    for (int r = 0; r < row_count; r++) begin
      apply_row(vectors[r]);
    end
    wait_drain();
    repeat (4) @(negedge clk);
    check_value("queue_full", 96'(queue_full), 96'(0));
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+tests
rtl/lsq_pkg.sv
rtl/store_data_buffer.sv
rtl/store_issue_queue.sv
rtl/store_port_lane.sv
rtl/store_commit.sv
tests/store_commit_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module store_commit_tb -f build.f &&
./obj_dir/Vstore_commit_tb | tee /dev/stderr | grep -qx "sim passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
